//--- src/busPkg.sv
// Bus fabric constants
package busPkg;

    // word and byte address widths of the master bus
    localparam int DataWidth = 32;
    localparam int AddrWidth = 32;

    // bytes per bus word, used to drop the byte bits from addresses
    localparam int ByteBits = 2;

    // on-chip sram window
    localparam logic [31:0] SramBase = 32'h0000_0000;
    localparam logic [31:0] SramSize = 32'h0000_0400;

    // slow external-style memory window
    // sits where the sdram would live on the full soc
    localparam logic [31:0] SlowBase = 32'h0100_0000;
    localparam logic [31:0] SlowSize = 32'h0000_0400;

    // number of mapped devices
    localparam int DeviceCount = 2;

    // device positions in the select and valid vectors
    localparam int SramIdx = 0;
    localparam int SlowIdx = 1;

endpackage

//--- src/slaveBus.sv
// Fabric to device bus
`timescale 1ns/10ps

interface slaveBus #(
    parameter int Words = 256
);
    import busPkg::*;

    // word address width follows the device depth
    localparam int WordBits = $clog2(Words);

    // request side, driven by the decoder
    logic                 read;
    logic                 write;
    logic [WordBits-1:0]  wordAddress;
    logic [DataWidth-1:0] writeData;

    // response side, driven by the device
    logic [DataWidth-1:0] readData;
    logic                 readValid;
    logic                 waitRequest;

    modport fabric (
        output read, write, wordAddress, writeData,
        input  readData, readValid, waitRequest
    );

    modport device (
        input  read, write, wordAddress, writeData,
        output readData, readValid, waitRequest
    );

endinterface

//--- src/addressDecoder.sv
// Address decode stage
`timescale 1ns/10ps

module addressDecoder #(
    parameter int SramWords = 256,
    parameter int SlowWords = 256
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic [busPkg::AddrWidth-1:0] address,
    input  logic                         read,
    input  logic                         write,
    input  logic [busPkg::DataWidth-1:0] writeData,
    output logic                         waitRequest,
    output logic                         defaultValid,
    slaveBus.fabric                      sramBus,
    slaveBus.fabric                      slowBus
);
    import busPkg::*;

    // word address bits each device needs
    localparam int SramBits = $clog2(SramWords);
    localparam int SlowBits = $clog2(SlowWords);

    logic [DeviceCount-1:0] hit;
    logic                   defaultRead;
    logic                   defaultPipe;

    // window compare, same pattern for every device
    assign hit[SramIdx] = (address >= SramBase) && (address <= (SramBase + (SramSize - 1)));
    assign hit[SlowIdx] = (address >= SlowBase) && (address <= (SlowBase + (SlowSize - 1)));

    // sram strobes
    assign sramBus.read        = read & hit[SramIdx];
    assign sramBus.write       = write & hit[SramIdx];
    assign sramBus.wordAddress = address[SramBits+ByteBits-1:ByteBits];
    assign sramBus.writeData   = writeData;

    // slow memory strobes
    assign slowBus.read        = read & hit[SlowIdx];
    assign slowBus.write       = write & hit[SlowIdx];
    assign slowBus.wordAddress = address[SlowBits+ByteBits-1:ByteBits];
    assign slowBus.writeData   = writeData;

    // stall only comes from the slow window
    assign waitRequest = hit[SlowIdx] & slowBus.waitRequest;

    // unmapped read gets a zero answer later on
    // unmapped writes just fall through
    assign defaultRead = read & ~|hit;

    // two stage delay for the default response
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            defaultPipe  <= 1'b0;
            defaultValid <= 1'b0;
        end else begin
            defaultPipe  <= defaultRead;
            defaultValid <= defaultPipe;
        end
    end

endmodule

//--- src/sramSlave.sv
// On-chip SRAM device
`timescale 1ns/10ps

module sramSlave #(
    parameter int SramWords = 256
) (
    input  logic    clk,
    input  logic    reset,
    slaveBus.device bus
);
    import busPkg::*;

    // word storage
    logic [DataWidth-1:0] mem [SramWords];

    // single cycle device, no stalls
    assign bus.waitRequest = 1'b0;

    // write lands on the accepting edge
    always_ff @(posedge clk) begin
        if (bus.write) begin
            mem[bus.wordAddress] <= bus.writeData;
        end
    end

    // read word shows up the next cycle
    always_ff @(posedge clk) begin
        if (bus.read) begin
            bus.readData <= mem[bus.wordAddress];
        end
    end

    // valid pulse lines up with the data register
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            bus.readValid <= 1'b0;
        end else begin
            bus.readValid <= bus.read;
        end
    end

endmodule

//--- src/waitStateSlave.sv
// Slow memory with wait states
`timescale 1ns/10ps

module waitStateSlave #(
    parameter int SlowWords  = 256,
    parameter int WaitCycles = 3
) (
    input  logic    clk,
    input  logic    reset,
    slaveBus.device bus
);
    import busPkg::*;

    // counter needs at least one bit even with zero wait states
    localparam int CountBits = (WaitCycles > 0) ? $clog2(WaitCycles + 1) : 1;
    localparam logic [CountBits-1:0] CountDone = CountBits'(WaitCycles);

    logic [DataWidth-1:0] mem [SlowWords];
    logic [CountBits-1:0] waitCount;
    logic                 strobe;
    logic                 stalled;
    logic                 accept;

    assign strobe = bus.read | bus.write;

    // hold the master off until enough cycles went by
    assign stalled = strobe && (waitCount != CountDone);
    assign accept  = strobe && !stalled;

    assign bus.waitRequest = stalled;

    // stall counter
    // restarts on acceptance or when the master gives up
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            waitCount     <= '0;
            bus.readValid <= 1'b0;
        end else begin
            if (!strobe || accept) begin
                waitCount <= '0;
            end else begin
                waitCount <= waitCount + 1'b1;
            end
            bus.readValid <= accept & bus.read;
        end
    end

    // storage access only once accepted
    always_ff @(posedge clk) begin
        if (accept && bus.write) begin
            mem[bus.wordAddress] <= bus.writeData;
        end
        if (accept && bus.read) begin
            bus.readData <= mem[bus.wordAddress];
        end
    end

endmodule

//--- src/responseMux.sv
// Read response selector
`timescale 1ns/10ps

module responseMux (
    input  logic [busPkg::DataWidth-1:0] sramData,
    input  logic                         sramValid,
    input  logic [busPkg::DataWidth-1:0] slowData,
    input  logic                         slowValid,
    input  logic                         defaultValid,
    output logic [busPkg::DataWidth-1:0] readData,
    output logic                         readValid
);
    import busPkg::*;

    // one-hot codes of each device in the valid vector
    localparam logic [DeviceCount-1:0] SramSel = DeviceCount'(1) << SramIdx;
    localparam logic [DeviceCount-1:0] SlowSel = DeviceCount'(1) << SlowIdx;

    logic [DeviceCount-1:0] validVec;

    always_comb begin
        validVec          = '0;
        validVec[SramIdx] = sramValid;
        validVec[SlowIdx] = slowValid;

        // exactly one valid picks its data
        // none or a collision gives zero, which also covers the default read
        case (validVec)
            SramSel: readData = sramData;
            SlowSel: readData = slowData;
            default: readData = '0;
        endcase

        readValid = |validVec | defaultValid;
    end

endmodule

//--- src/socInterconnectTop.sv
// SoC bus interconnect
`timescale 1ns/10ps

module socInterconnectTop #(
    parameter int SramWords  = 256,
    parameter int SlowWords  = 256,
    parameter int WaitCycles = 3
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic [busPkg::AddrWidth-1:0] address,
    input  logic                         read,
    input  logic                         write,
    input  logic [busPkg::DataWidth-1:0] writeData,
    output logic                         waitRequest,
    output logic                         readValid,
    output logic [busPkg::DataWidth-1:0] readData
);

    // zero answer strobe for unmapped reads
    logic defaultValid;

    // one bus per device
    slaveBus #(.Words(SramWords)) sramBus ();
    slaveBus #(.Words(SlowWords)) slowBus ();

    // decode stage
    addressDecoder #(
        .SramWords (SramWords),
        .SlowWords (SlowWords)
    ) i_addressDecoder (
        .clk          (clk),
        .reset        (reset),
        .address      (address),
        .read         (read),
        .write        (write),
        .writeData    (writeData),
        .waitRequest  (waitRequest),
        .defaultValid (defaultValid),
        .sramBus      (sramBus.fabric),
        .slowBus      (slowBus.fabric)
    );

    // fast memory
    sramSlave #(
        .SramWords (SramWords)
    ) i_sramSlave (
        .clk   (clk),
        .reset (reset),
        .bus   (sramBus.device)
    );

    // slow memory
    waitStateSlave #(
        .SlowWords  (SlowWords),
        .WaitCycles (WaitCycles)
    ) i_waitStateSlave (
        .clk   (clk),
        .reset (reset),
        .bus   (slowBus.device)
    );

    // response stage
    responseMux i_responseMux (
        .sramData     (sramBus.readData),
        .sramValid    (sramBus.readValid),
        .slowData     (slowBus.readData),
        .slowValid    (slowBus.readValid),
        .defaultValid (defaultValid),
        .readData     (readData),
        .readValid    (readValid)
    );

endmodule

//--- tb/interconnect_asserts.sv
// Interconnect protocol checks
`timescale 1ns/10ps

module interconnectAsserts (
    input logic clk,
    input logic reset,
    input logic sramRead,
    input logic sramWrite,
    input logic slowRead,
    input logic slowWrite,
    input logic sramValid,
    input logic slowValid,
    input logic defaultValid,
    input logic waitRequest
);

    // number of failed checks, read by the testbench at the end
    int failCount = 0;

    sramStrobesExclusive: assert property (@(posedge clk) disable iff (reset)
        !(sramRead && sramWrite))
        else begin
            failCount++;
            $error("sram bus has read and write high together");
        end

    slowStrobesExclusive: assert property (@(posedge clk) disable iff (reset)
        !(slowRead && slowWrite))
        else begin
            failCount++;
            $error("slow bus has read and write high together");
        end

    // at most one responder per cycle
    validOneHot: assert property (@(posedge clk) disable iff (reset)
        $onehot0({sramValid, slowValid, defaultValid}))
        else begin
            failCount++;
            $error("more than one read response in the same cycle");
        end

    sramReadLatency: assert property (@(posedge clk) disable iff (reset)
        sramRead |=> sramValid)
        else begin
            failCount++;
            $error("sram read not answered one cycle later");
        end

    idleAfterReset: assert property (@(posedge clk) $fell(reset) |-> !waitRequest)
        else begin
            failCount++;
            $error("waitRequest high right after reset");
        end

endmodule

bind addressDecoder interconnectAsserts i_interconnectAsserts (
    .clk          (clk),
    .reset        (reset),
    .sramRead     (sramBus.read),
    .sramWrite    (sramBus.write),
    .slowRead     (slowBus.read),
    .slowWrite    (slowBus.write),
    .sramValid    (sramBus.readValid),
    .slowValid    (slowBus.readValid),
    .defaultValid (defaultValid),
    .waitRequest  (waitRequest)
);

//--- tb/socInterconnectTb.sv
// Interconnect testbench
`timescale 1ns/10ps

module socInterconnectTb;
    import busPkg::*;

    localparam int ClockPeriod = 100;
    // sample point sits between the falling and the rising edge
    localparam int SampleDelay = ClockPeriod / 4;
    localparam int WaitCycles  = 3;

    logic                 clk;
    logic                 reset;
    logic [AddrWidth-1:0] address;
    logic                 read;
    logic                 write;
    logic [DataWidth-1:0] writeData;
    logic                 waitRequest;
    logic                 readValid;
    logic [DataWidth-1:0] readData;

    // access list from the data file
    int                   opList[$];
    logic [AddrWidth-1:0] addrList[$];
    logic [DataWidth-1:0] dataList[$];
    logic [DataWidth-1:0] expList[$];
    int                   lineCount = 0;

    socInterconnectTop #(
        .SramWords  (256),
        .SlowWords  (256),
        .WaitCycles (WaitCycles)
    ) i_socInterconnectTop (
        .clk         (clk),
        .reset       (reset),
        .address     (address),
        .read        (read),
        .write       (write),
        .writeData   (writeData),
        .waitRequest (waitRequest),
        .readValid   (readValid),
        .readData    (readData)
    );

    always #(ClockPeriod / 2) clk = ~clk;

    task automatic stopOnError(input string why);
        $display("%s", why);
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected) begin
            stopOnError($sformatf("Fail %s: got 0x%08h, expected 0x%08h",
                                  name, actual, expected));
        end
    endtask

    // stall cycles the address map implies
    function automatic int stallsFor(input logic [AddrWidth-1:0] addr);
        if (addr >= SlowBase && addr < SlowBase + SlowSize) begin
            return WaitCycles;
        end
        return 0;
    endfunction

    // unmapped reads answer one cycle later than real devices
    function automatic int latencyFor(input logic [AddrWidth-1:0] addr);
        if (addr >= SramBase && addr < SramBase + SramSize) begin
            return 1;
        end
        if (addr >= SlowBase && addr < SlowBase + SlowSize) begin
            return 1;
        end
        return 2;
    endfunction

    task automatic loadAccesses();
        int                   fd;
        int                   c;
        int                   n;
        logic [31:0]          a;
        logic [31:0]          d;
        logic [31:0]          e;
        fd = $fopen("tb/interconnect_input.txt", "r");
        if (fd == 0) begin
            stopOnError("cannot open tb/interconnect_input.txt");
        end
        c = $fgetc(fd);
        while (c != -1) begin
            if (c == "#") begin
                // skip the rest of a comment line
                while (c != "\n" && c != -1) begin
                    c = $fgetc(fd);
                end
            end else if (c == "R" || c == "W" || c == "B") begin
                n = $fscanf(fd, "%h %h %h", a, d, e);
                if (n != 3) begin
                    stopOnError("malformed line in the access list");
                end
                opList.push_back(c);
                addrList.push_back(a);
                dataList.push_back(d);
                expList.push_back(e);
            end else if (c > 32) begin
                stopOnError("unknown operation in the access list");
            end
            if (c != -1) begin
                c = $fgetc(fd);
            end
        end
        $fclose(fd);
        if (opList.size() == 0) begin
            stopOnError("access list is empty");
        end
        lineCount = opList.size();
    endtask

    task automatic writeWord(input logic [31:0] addr, input logic [31:0] data);
        int stalls;
        stalls = 0;
        @(negedge clk);
        address   = addr;
        writeData = data;
        write     = 1'b1;
        #SampleDelay;
        while (waitRequest) begin
            stalls++;
            @(negedge clk);
            #SampleDelay;
        end
        // accepted on the rising edge just passed
        @(negedge clk);
        write = 1'b0;
        checkValue("waitRequest cycles", stalls, stallsFor(addr));
    endtask

    task automatic readWord(input logic [31:0] addr, input logic [31:0] expected);
        int stalls;
        int latency;
        stalls = 0;
        @(negedge clk);
        address = addr;
        read    = 1'b1;
        #SampleDelay;
        while (waitRequest) begin
            // nothing else is in flight here
            checkValue("readValid", readValid, 0);
            stalls++;
            @(negedge clk);
            #SampleDelay;
        end
        @(negedge clk);
        read    = 1'b0;
        latency = 1;
        #SampleDelay;
        while (!readValid) begin
            latency++;
            @(negedge clk);
            #SampleDelay;
        end
        checkValue("waitRequest cycles", stalls, stallsFor(addr));
        checkValue("readValid latency", latency, latencyFor(addr));
        checkValue("readData", readData, expected);
    endtask

    // two sram reads on consecutive cycles
    task automatic readPair(input logic [31:0] addrA, input logic [31:0] expA,
                            input logic [31:0] addrB, input logic [31:0] expB);
        if (latencyFor(addrA) != 1 || stallsFor(addrA) != 0 ||
            latencyFor(addrB) != 1 || stallsFor(addrB) != 0) begin
            stopOnError("back-to-back reads must target the SRAM window");
        end
        @(negedge clk);
        address = addrA;
        read    = 1'b1;
        #SampleDelay;
        checkValue("waitRequest", waitRequest, 0);
        // second request while the first answer is on the bus
        @(negedge clk);
        address = addrB;
        #SampleDelay;
        checkValue("readValid", readValid, 1);
        checkValue("readData", readData, expA);
        @(negedge clk);
        read = 1'b0;
        #SampleDelay;
        checkValue("readValid", readValid, 1);
        checkValue("readData", readData, expB);
    endtask

    initial begin
        int idx;
        clk       = 1'b0;
        reset     = 1'b1;
        address   = '0;
        read      = 1'b0;
        write     = 1'b0;
        writeData = '0;
        loadAccesses();
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        idx   = 0;
        while (idx < lineCount) begin
            if (opList[idx] == "W") begin
                writeWord(addrList[idx], dataList[idx]);
                idx++;
            end else if (opList[idx] == "R") begin
                readWord(addrList[idx], expList[idx]);
                idx++;
            end else begin
                if (idx + 1 >= lineCount || opList[idx + 1] != "B") begin
                    stopOnError("back-to-back read line has no partner line");
                end
                readPair(addrList[idx], expList[idx], addrList[idx + 1], expList[idx + 1]);
                idx += 2;
            end
        end
        // a few idle cycles so the bound checks see the tail
        repeat (2) @(negedge clk);
        if (i_socInterconnectTop.i_addressDecoder.i_interconnectAsserts.failCount != 0) begin
            stopOnError("bound assertions flagged a bus protocol error");
        end else begin
            $display("ALL TESTS PASSED");
            $finish;
        end
    end

    // budget of a few cycles more than the slowest access per line
    initial begin
        wait (lineCount != 0);
        #((lineCount * (WaitCycles + 6) + 4) * ClockPeriod);
        stopOnError("run hung waiting for the bus to answer");
    end

endmodule

//--- tb/interconnect_input.txt
# op address writeData expected, all hex; R read and check, W write (expected unused)
# B lines come in pairs and are read on consecutive cycles
W 00000000 11111111 00000000
W 000003fc a5a5a5a5 00000000
W 00000124 0badcafe 00000000
R 00000000 00000000 11111111
R 000003fc 00000000 a5a5a5a5
R 00000124 00000000 0badcafe
W 01000008 cafef00d 00000000
R 01000008 00000000 cafef00d
W 010003fc 13572468 00000000
R 010003fc 00000000 13572468
R 00004000 00000000 00000000
R 01000400 00000000 00000000
W 00004000 deadbeef 00000000
R 00000000 00000000 11111111
W 00000040 aaaa0040 00000000
W 01000040 bbbb0040 00000000
R 00000040 00000000 aaaa0040
R 01000040 00000000 bbbb0040
W 00000080 80808080 00000000
B 00000080 00000000 80808080
B 00000124 00000000 0badcafe
B 000003fc 00000000 a5a5a5a5
B 00000000 00000000 11111111

//--- filelist.f
src/busPkg.sv
src/slaveBus.sv
src/addressDecoder.sv
src/sramSlave.sv
src/waitStateSlave.sv
src/responseMux.sv
src/socInterconnectTop.sv
tb/interconnect_asserts.sv
tb/socInterconnectTb.sv

//--- Bender.yml
package:
  name: soc_interconnect

sources:
  - files:
      - src/busPkg.sv
      - src/slaveBus.sv
      - src/addressDecoder.sv
      - src/sramSlave.sv
      - src/waitStateSlave.sv
      - src/responseMux.sv
      - src/socInterconnectTop.sv
  - target: test
    files:
      - tb/interconnect_asserts.sv
      - tb/socInterconnectTb.sv
